// File: obi_config.svh
// Configuration macros for port count, outstanding transfer limit and OBI field widths
`ifndef OBI_CONFIG_SVH
`define OBI_CONFIG_SVH

// Number of requester ports sharing the external bus
// The arbiter needs at least 2 of them
`define OBI_NUM_PORTS 2

// Largest number of granted transfers still awaiting a response
// Must be a power of two since the owner FIFO wraps its pointers
`define OBI_MAX_OUTST 4

// Address phase field widths
`define OBI_ADDR_W 32
`define OBI_DATA_W 32
`define OBI_BE_W   (`OBI_DATA_W / 8)
`define OBI_ATOP_W 6

`endif

// File: obi_pkg.sv
// Shared types for the OBI front end: adapter FSM state and requester port index
`include "obi_config.svh"

package obi_pkg;

  //////////////////////////////////////////////////
  // Adapter FSM
  //////////////////////////////////////////////////

  // TRANSPARENT passes the request straight to the link
  // REGISTERED replays a captured address phase until granted
  typedef enum logic {
    TRANSPARENT = 1'b0,
    REGISTERED  = 1'b1
  } adapter_state_t;

  //////////////////////////////////////////////////
  // Port numbering
  //////////////////////////////////////////////////

  // Wide enough to name every requester port
  typedef logic [$clog2(`OBI_NUM_PORTS)-1:0] port_idx_t;

endpackage

// File: obi_owner_fifo.sv
// Circular buffer of port indices naming the owner of each outstanding bus transfer
`include "obi_config.svh"

module obi_owner_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  obi_pkg::port_idx_t  push_idx_i,
  input  logic                pop_i,
  output obi_pkg::port_idx_t  head_idx_o,
  output logic                empty_o,
  output logic                full_o
);

  localparam int unsigned DEPTH = `OBI_MAX_OUTST;
  localparam int unsigned AW    = $clog2(DEPTH);

  // Storage holds owners in grant order
  obi_pkg::port_idx_t mem_q [DEPTH];

  // Pointers carry one extra wrap bit to tell full from empty
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;

  //////////////////////////////////////////////////
  // Pointer update
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Each new owner lands in the slot at the write pointer
  always_ff @(posedge clk)
  begin
    if (push_i)
      mem_q[wr_ptr_q[AW-1:0]] <= push_idx_i;
  end

  assign head_idx_o = mem_q[rd_ptr_q[AW-1:0]];
  assign empty_o    = (wr_ptr_q == rd_ptr_q);
  // Same slot but opposite wrap bits means every slot is taken
  assign full_o     = (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]) && (wr_ptr_q[AW] != rd_ptr_q[AW]);

  // The arbiter gates its bus request on full_o, so overflow means a gating bug
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o);
  // Popping an empty FIFO would misroute every later response
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

// File: obi_adapter.sv
// Per-port request adapter turning valid/ready requests into a stable OBI address phase
`include "obi_config.svh"

module obi_adapter #(
  parameter bit TRANS_STABLE = 1'b0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // Requester side
  input  logic                   trans_valid_i,
  output logic                   trans_ready_o,
  input  logic [`OBI_ADDR_W-1:0] trans_addr_i,
  input  logic                   trans_we_i,
  input  logic [`OBI_BE_W-1:0]   trans_be_i,
  input  logic [`OBI_DATA_W-1:0] trans_wdata_i,
  input  logic [`OBI_ATOP_W-1:0] trans_atop_i,
  // OBI address phase towards the arbiter
  output logic                   obi_req_o,
  input  logic                   obi_gnt_i,
  output logic [`OBI_ADDR_W-1:0] obi_addr_o,
  output logic                   obi_we_o,
  output logic [`OBI_BE_W-1:0]   obi_be_o,
  output logic [`OBI_DATA_W-1:0] obi_wdata_o,
  output logic [`OBI_ATOP_W-1:0] obi_atop_o
);

  if (TRANS_STABLE) begin : g_pass
    // The requester already keeps its fields steady, so no capture is needed
    assign obi_req_o     = trans_valid_i;
    assign obi_addr_o    = trans_addr_i;
    assign obi_we_o      = trans_we_i;
    assign obi_be_o      = trans_be_i;
    assign obi_wdata_o   = trans_wdata_i;
    assign obi_atop_o    = trans_atop_i;
    // Acceptance coincides with the grant here
    assign trans_ready_o = obi_gnt_i;
  end else begin : g_fsm
    obi_pkg::adapter_state_t state_q;
    obi_pkg::adapter_state_t state_d;

    // Captured address phase, replayed while waiting for the grant
    logic [`OBI_ADDR_W-1:0] addr_q;
    logic                   we_q;
    logic [`OBI_BE_W-1:0]   be_q;
    logic [`OBI_DATA_W-1:0] wdata_q;
    logic [`OBI_ATOP_W-1:0] atop_q;

    //////////////////////////////////////////////////
    // State transitions
    //////////////////////////////////////////////////

    always_comb
    begin
      state_d = state_q;
      case (state_q)
        // An ungranted request must be frozen from the next cycle on
        obi_pkg::TRANSPARENT:
          if (obi_req_o && !obi_gnt_i)
          begin
            state_d = obi_pkg::REGISTERED;
          end
        // Release once the link has taken the transfer
        obi_pkg::REGISTERED:
          if (obi_gnt_i)
          begin
            state_d = obi_pkg::TRANSPARENT;
          end
        default: state_d = obi_pkg::TRANSPARENT;
      endcase
    end

    // Output mux between the live request and the captured copy
    always_comb
    begin
      if (state_q == obi_pkg::TRANSPARENT)
      begin
        obi_req_o   = trans_valid_i;
        obi_addr_o  = trans_addr_i;
        obi_we_o    = trans_we_i;
        obi_be_o    = trans_be_i;
        obi_wdata_o = trans_wdata_i;
        obi_atop_o  = trans_atop_i;
      end
      else
      begin
        // A raised request is never withdrawn
        obi_req_o   = 1'b1;
        obi_addr_o  = addr_q;
        obi_we_o    = we_q;
        obi_be_o    = be_q;
        obi_wdata_o = wdata_q;
        obi_atop_o  = atop_q;
      end
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        state_q <= obi_pkg::TRANSPARENT;
      end
      else
      begin
        state_q <= state_d;
      end
    end

    // Capture only on the way into REGISTERED
    always_ff @(posedge clk)
    begin
      if (state_q == obi_pkg::TRANSPARENT && state_d == obi_pkg::REGISTERED)
      begin
        addr_q  <= trans_addr_i;
        we_q    <= trans_we_i;
        be_q    <= trans_be_i;
        wdata_q <= trans_wdata_i;
        atop_q  <= trans_atop_i;
      end
    end

    // A new request is taken only while nothing is parked
    assign trans_ready_o = (state_q == obi_pkg::TRANSPARENT);

    // Across the capture boundary the link must look unchanged
    a_link_stable: assert property (@(posedge clk) disable iff (!rst_n)
      obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o)
        && $stable(obi_be_o) && $stable(obi_wdata_o) && $stable(obi_atop_o));
  end

endmodule

// File: obi_arbiter.sv
// Round-robin OBI arbiter with grant lock, outstanding limit and in-order response steering
`include "obi_config.svh"

module obi_arbiter (
  input  logic                                       clk,
  input  logic                                       rst_n,
  // Address phase from the adapters
  input  logic [`OBI_NUM_PORTS-1:0]                  port_req_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_ADDR_W-1:0] port_addr_i,
  input  logic [`OBI_NUM_PORTS-1:0]                  port_we_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_BE_W-1:0]   port_be_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] port_wdata_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_ATOP_W-1:0] port_atop_i,
  output logic [`OBI_NUM_PORTS-1:0]                  port_gnt_o,
  // Responses back to each port
  output logic [`OBI_NUM_PORTS-1:0]                  resp_valid_o,
  output logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] resp_rdata_o,
  output logic [`OBI_NUM_PORTS-1:0]                  resp_err_o,
  // Shared external bus
  output logic                                       obi_req_o,
  input  logic                                       obi_gnt_i,
  output logic [`OBI_ADDR_W-1:0]                     obi_addr_o,
  output logic                                       obi_we_o,
  output logic [`OBI_BE_W-1:0]                       obi_be_o,
  output logic [`OBI_DATA_W-1:0]                     obi_wdata_o,
  output logic [`OBI_ATOP_W-1:0]                     obi_atop_o,
  input  logic                                       obi_rvalid_i,
  input  logic [`OBI_DATA_W-1:0]                     obi_rdata_i,
  input  logic                                       obi_err_i
);

  localparam int unsigned NP = `OBI_NUM_PORTS;

  obi_pkg::port_idx_t rr_q;        // Port with highest priority this cycle
  obi_pkg::port_idx_t lock_idx_q;  // Port that owns an ungranted bus request
  logic               lock_q;
  obi_pkg::port_idx_t rr_win;
  obi_pkg::port_idx_t sel_idx;
  obi_pkg::port_idx_t head_idx;
  logic               fifo_empty;
  logic               fifo_full;
  logic               bus_grant;

  //////////////////////////////////////////////////
  // Port selection
  //////////////////////////////////////////////////

  // Scan ports starting at the round-robin pointer, first requester wins
  always_comb
  begin
    int  cand;
    logic found;
    rr_win = rr_q;
    found  = 1'b0;
    for (int i = 0; i < NP; i++)
    begin
      cand = (int'(rr_q) + i) % NP;
      if (!found && port_req_i[cand])
      begin
        rr_win = obi_pkg::port_idx_t'(cand);
        found  = 1'b1;
      end
    end
  end

  // While locked the bus must keep presenting the same port
  assign sel_idx = lock_q ? lock_idx_q : rr_win;

  // No new request once the owner FIFO cannot record another transfer
  assign obi_req_o   = port_req_i[sel_idx] && !fifo_full;
  assign obi_addr_o  = port_addr_i[sel_idx];
  assign obi_we_o    = port_we_i[sel_idx];
  assign obi_be_o    = port_be_i[sel_idx];
  assign obi_wdata_o = port_wdata_i[sel_idx];
  assign obi_atop_o  = port_atop_i[sel_idx];

  assign bus_grant = obi_req_o && obi_gnt_i;

  // Only the selected port sees the bus grant
  always_comb
  begin
    port_gnt_o          = '0;
    port_gnt_o[sel_idx] = bus_grant;
  end

  //////////////////////////////////////////////////
  // Lock and priority state
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end
    else
    begin
      if (obi_req_o && !obi_gnt_i)
      begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel_idx;
      end
      else if (bus_grant)
      begin
        lock_q <= 1'b0;
      end
      // Winner drops to lowest priority after its grant
      if (bus_grant)
        rr_q <= (sel_idx == obi_pkg::port_idx_t'(NP - 1)) ? '0 : sel_idx + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////

  obi_owner_fifo i_owner_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (bus_grant),
    .push_idx_i (sel_idx),
    .pop_i      (obi_rvalid_i),
    .head_idx_o (head_idx),
    .empty_o    (fifo_empty),
    .full_o     (fifo_full)
  );

  // Data and error fan out, valid goes to the owner only
  always_comb
  begin
    for (int p = 0; p < NP; p++)
    begin
      resp_valid_o[p] = obi_rvalid_i && (head_idx == obi_pkg::port_idx_t'(p));
      resp_rdata_o[p] = obi_rdata_i;
      resp_err_o[p]   = obi_err_i;
    end
  end

  // The slave answers only transfers it has granted
  a_rvalid_owned: assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> !fifo_empty);
  // The locked adapter keeps requesting, so the bus request cannot drop
  a_lock_holds_req: assert property (@(posedge clk) disable iff (!rst_n)
    lock_q |-> obi_req_o);

endmodule

// File: obi_subsystem.sv
// Top level of the OBI front end: per-port adapters in a generate loop feeding one arbiter
`include "obi_config.svh"

module obi_subsystem (
  input  logic                                       clk,
  input  logic                                       rst_n,
  // Requester ports
  input  logic [`OBI_NUM_PORTS-1:0]                  trans_valid_i,
  output logic [`OBI_NUM_PORTS-1:0]                  trans_ready_o,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_ADDR_W-1:0] trans_addr_i,
  input  logic [`OBI_NUM_PORTS-1:0]                  trans_we_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_BE_W-1:0]   trans_be_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] trans_wdata_i,
  input  logic [`OBI_NUM_PORTS-1:0][`OBI_ATOP_W-1:0] trans_atop_i,
  // Per-port responses
  output logic [`OBI_NUM_PORTS-1:0]                  resp_valid_o,
  output logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] resp_rdata_o,
  output logic [`OBI_NUM_PORTS-1:0]                  resp_err_o,
  // External OBI bus
  output logic                                       obi_req_o,
  input  logic                                       obi_gnt_i,
  output logic [`OBI_ADDR_W-1:0]                     obi_addr_o,
  output logic                                       obi_we_o,
  output logic [`OBI_BE_W-1:0]                       obi_be_o,
  output logic [`OBI_DATA_W-1:0]                     obi_wdata_o,
  output logic [`OBI_ATOP_W-1:0]                     obi_atop_o,
  input  logic                                       obi_rvalid_i,
  input  logic [`OBI_DATA_W-1:0]                     obi_rdata_i,
  input  logic                                       obi_err_i
);

  // Internal links between the adapters and the arbiter
  logic [`OBI_NUM_PORTS-1:0]                  link_req;
  logic [`OBI_NUM_PORTS-1:0]                  link_gnt;
  logic [`OBI_NUM_PORTS-1:0][`OBI_ADDR_W-1:0] link_addr;
  logic [`OBI_NUM_PORTS-1:0]                  link_we;
  logic [`OBI_NUM_PORTS-1:0][`OBI_BE_W-1:0]   link_be;
  logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] link_wdata;
  logic [`OBI_NUM_PORTS-1:0][`OBI_ATOP_W-1:0] link_atop;

  // Requesters may change fields while waiting, so every adapter registers
  for (genvar g = 0; g < `OBI_NUM_PORTS; g++)
  begin : g_port
    obi_adapter #(.TRANS_STABLE(1'b0)) i_adapter (
      .clk           (clk),
      .rst_n         (rst_n),
      .trans_valid_i (trans_valid_i[g]),
      .trans_ready_o (trans_ready_o[g]),
      .trans_addr_i  (trans_addr_i[g]),
      .trans_we_i    (trans_we_i[g]),
      .trans_be_i    (trans_be_i[g]),
      .trans_wdata_i (trans_wdata_i[g]),
      .trans_atop_i  (trans_atop_i[g]),
      .obi_req_o     (link_req[g]),
      .obi_gnt_i     (link_gnt[g]),
      .obi_addr_o    (link_addr[g]),
      .obi_we_o      (link_we[g]),
      .obi_be_o      (link_be[g]),
      .obi_wdata_o   (link_wdata[g]),
      .obi_atop_o    (link_atop[g])
    );
  end

  obi_arbiter i_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .port_req_i   (link_req),
    .port_addr_i  (link_addr),
    .port_we_i    (link_we),
    .port_be_i    (link_be),
    .port_wdata_i (link_wdata),
    .port_atop_i  (link_atop),
    .port_gnt_o   (link_gnt),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o),
    .obi_req_o    (obi_req_o),
    .obi_gnt_i    (obi_gnt_i),
    .obi_addr_o   (obi_addr_o),
    .obi_we_o     (obi_we_o),
    .obi_be_o     (obi_be_o),
    .obi_wdata_o  (obi_wdata_o),
    .obi_atop_o   (obi_atop_o),
    .obi_rvalid_i (obi_rvalid_i),
    .obi_rdata_i  (obi_rdata_i),
    .obi_err_i    (obi_err_i)
  );

endmodule

// File: tb_obi_subsystem.sv
// Testbench for the OBI front end with random requesters, a bus slave memory model and checkers
`include "obi_config.svh"

module tb_obi_subsystem;

  localparam int NP        = `OBI_NUM_PORTS;
  localparam int PER_PORT  = 100;
  localparam int NUM_TRANS = PER_PORT * NP;
  localparam int MAX_STALL = 3;
  localparam int MAX_DELAY = 7;
  // Cycles allowed for the whole run plus a little room for reset
  localparam int WATCHDOG  = NUM_TRANS * (MAX_STALL + MAX_DELAY) * 2 + 10;
  // Words in this address range answer with an error
  localparam logic [`OBI_ADDR_W-1:0] ERR_BASE = 'h80;
  localparam logic [`OBI_ADDR_W-1:0] ERR_END  = 'hC0;
  localparam logic [31:0] LFSR_SEED = 32'h39d6;
  // Width of one packed address phase {addr, we, be, wdata, atop}
  localparam int FW = `OBI_ADDR_W + 1 + `OBI_BE_W + `OBI_DATA_W + `OBI_ATOP_W;

  logic                                       clk = 1'b0;
  logic                                       rst_n;
  logic [`OBI_NUM_PORTS-1:0]                  trans_valid_i;
  logic [`OBI_NUM_PORTS-1:0]                  trans_ready_o;
  logic [`OBI_NUM_PORTS-1:0][`OBI_ADDR_W-1:0] trans_addr_i;
  logic [`OBI_NUM_PORTS-1:0]                  trans_we_i;
  logic [`OBI_NUM_PORTS-1:0][`OBI_BE_W-1:0]   trans_be_i;
  logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] trans_wdata_i;
  logic [`OBI_NUM_PORTS-1:0][`OBI_ATOP_W-1:0] trans_atop_i;
  logic [`OBI_NUM_PORTS-1:0]                  resp_valid_o;
  logic [`OBI_NUM_PORTS-1:0][`OBI_DATA_W-1:0] resp_rdata_o;
  logic [`OBI_NUM_PORTS-1:0]                  resp_err_o;
  logic                                       obi_req_o;
  logic                                       obi_gnt_i;
  logic [`OBI_ADDR_W-1:0]                     obi_addr_o;
  logic                                       obi_we_o;
  logic [`OBI_BE_W-1:0]                       obi_be_o;
  logic [`OBI_DATA_W-1:0]                     obi_wdata_o;
  logic [`OBI_ATOP_W-1:0]                     obi_atop_o;
  logic                                       obi_rvalid_i;
  logic [`OBI_DATA_W-1:0]                     obi_rdata_i;
  logic                                       obi_err_i;

  logic [31:0]            lfsr_q = LFSR_SEED;
  // Accepted but not yet granted address phases in order for each port
  logic [FW-1:0]          pend_q [NP][$];
  // Expected {err, rdata} per port that the model fills at grant time
  logic [`OBI_DATA_W:0]   exp_q [NP][$];
  // Slave reply pipeline with the cycle each reply becomes due
  logic [`OBI_DATA_W:0]   rsp_q [$];
  int                     due_q [$];
  logic [`OBI_DATA_W-1:0] mem [logic [`OBI_ADDR_W-3:0]];
  int                     accepted [NP];
  int                     cycle;
  int                     stall_cnt;
  int                     grants;
  int                     resps;
  int                     leftover;

  obi_subsystem i_dut (.*);

  always #5 clk = ~clk;

  // Fibonacci LFSR with taps 32, 22, 2 and 1 stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp, input logic [31:0] act);
    abort_run($sformatf("error: test %s expected %0h actual %0h", test, exp, act));
  endtask

  //////////////////////////////////////////////////
  // Requesters and bus slave
  //////////////////////////////////////////////////

  // All random draws happen here so their order is fixed
  always @(posedge clk)
  begin
    logic [31:0]            r;
    int                     owner;
    logic [`OBI_DATA_W-1:0] word;
    logic [`OBI_DATA_W:0]   rsp;
    if (rst_n)
    begin
      cycle++;
      for (int p = 0; p < NP; p++)
      begin
        // Whatever sits on the port at an accepting edge is the transfer
        if (trans_valid_i[p] && trans_ready_o[p])
        begin
          pend_q[p].push_back({trans_addr_i[p], trans_we_i[p], trans_be_i[p],
                               trans_wdata_i[p], trans_atop_i[p]});
          accepted[p]++;
        end
        // Fields are redrawn every cycle, even while the port waits
        r = rand_bits(2);
        trans_valid_i[p] <= (accepted[p] < PER_PORT) && (r[1:0] != 2'b00);
        r = rand_bits(6);
        trans_addr_i[p]  <= {{(`OBI_ADDR_W-8){1'b0}}, r[5:0], 2'b00};
        r = rand_bits(1);
        trans_we_i[p]    <= r[0];
        r = rand_bits(`OBI_BE_W);
        trans_be_i[p]    <= r[`OBI_BE_W-1:0];
        r = rand_bits(`OBI_DATA_W);
        trans_wdata_i[p] <= r[`OBI_DATA_W-1:0];
        r = rand_bits(`OBI_ATOP_W);
        trans_atop_i[p]  <= r[`OBI_ATOP_W-1:0];
      end

      if (obi_req_o && obi_gnt_i)
      begin
        // The owner is the port whose oldest pending transfer is on the bus
        owner = -1;
        for (int p = NP - 1; p >= 0; p--)
        begin
          if (pend_q[p].size() > 0 && pend_q[p][0] ==
              {obi_addr_o, obi_we_o, obi_be_o, obi_wdata_o, obi_atop_o})
            owner = p;
        end
        assert (owner >= 0)
          else abort_run("granted bus transfer matches no port's oldest pending request");
        if (owner >= 0)
        begin
          void'(pend_q[owner].pop_front());
          word = mem.exists(obi_addr_o[`OBI_ADDR_W-1:2]) ? mem[obi_addr_o[`OBI_ADDR_W-1:2]]
                                                          : ~{obi_addr_o[`OBI_ADDR_W-1:2], 2'b00};
          if (obi_addr_o >= ERR_BASE && obi_addr_o < ERR_END)
            rsp = {1'b1, {`OBI_DATA_W{1'b0}}};
          else if (obi_we_o)
          begin
            for (int b = 0; b < `OBI_BE_W; b++)
              if (obi_be_o[b])
                word[8*b +: 8] = obi_wdata_o[8*b +: 8];
            mem[obi_addr_o[`OBI_ADDR_W-1:2]] = word;
            rsp = '0;
          end
          else
            rsp = {1'b0, word};
          exp_q[owner].push_back(rsp);
          rsp_q.push_back(rsp);
          r = rand_bits(3);
          due_q.push_back(cycle + int'(r[2:0]));
        end
        r = rand_bits(2);
        stall_cnt = int'(r[1:0]);
      end

      // Grant stalls follow each grant
      if (stall_cnt == 0)
        obi_gnt_i <= 1'b1;
      else
      begin
        obi_gnt_i <= 1'b0;
        stall_cnt--;
      end

      // Replies leave strictly in grant order
      if (rsp_q.size() > 0 && due_q[0] <= cycle)
      begin
        rsp = rsp_q.pop_front();
        void'(due_q.pop_front());
        obi_rvalid_i <= 1'b1;
        obi_err_i    <= rsp[`OBI_DATA_W];
        obi_rdata_i  <= rsp[`OBI_DATA_W-1:0];
      end
      else
      begin
        obi_rvalid_i <= 1'b0;
        obi_rdata_i  <= '0;
        obi_err_i    <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checkers
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [`OBI_DATA_W:0] exp;
    if (rst_n)
    begin
      if (obi_req_o && obi_gnt_i)
        grants++;
      // Responses are counted where the ports receive them
      resps += $countones(resp_valid_o);
      assert (resps <= grants) else abort_run("ports received more responses than grants");
      assert (grants - resps <= `OBI_MAX_OUTST)
        else abort_run("outstanding transfers exceeded the limit");
      for (int p = 0; p < NP; p++)
      begin
        if (resp_valid_o[p])
        begin
          assert (exp_q[p].size() > 0)
            else abort_run($sformatf("response on port %0d with nothing expected", p));
          exp = exp_q[p].pop_front();
          assert (resp_rdata_o[p] == exp[`OBI_DATA_W-1:0])
            else report_mismatch($sformatf("resp_rdata_port%0d", p),
                                 exp[`OBI_DATA_W-1:0], resp_rdata_o[p]);
          assert (resp_err_o[p] == exp[`OBI_DATA_W])
            else report_mismatch($sformatf("resp_err_port%0d", p),
                                 32'(exp[`OBI_DATA_W]), 32'(resp_err_o[p]));
        end
      end
    end
  end

  // An ungranted bus request stays up with the same address phase
  a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_o && !obi_gnt_i |=> obi_req_o && $stable(obi_addr_o) && $stable(obi_we_o)
      && $stable(obi_be_o) && $stable(obi_wdata_o) && $stable(obi_atop_o))
    else abort_run("bus request dropped or changed before its grant");

  initial
  begin
    rst_n         = 1'b0;
    trans_valid_i = '0;
    trans_addr_i  = '0;
    trans_we_i    = '0;
    trans_be_i    = '0;
    trans_wdata_i = '0;
    trans_atop_i  = '0;
    obi_gnt_i     = 1'b0;
    obi_rvalid_i  = 1'b0;
    obi_rdata_i   = '0;
    obi_err_i     = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    // Inputs are still idle here, so the DUT must show its reset state
    @(negedge clk);
    assert (!obi_req_o && resp_valid_o == '0 && trans_ready_o == '1)
      else abort_run("outputs not idle after reset");
    while (resps < NUM_TRANS)
      @(negedge clk);
    repeat (2) @(negedge clk);
    leftover = rsp_q.size();
    for (int p = 0; p < NP; p++)
      leftover += exp_q[p].size() + pend_q[p].size();
    if (leftover != 0)
      abort_run($sformatf("%0d transfers still unanswered at end of run", leftover));
    else
    begin
      $display("Test passed");
      $finish;
    end
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG * 10);
    abort_run("watchdog expired before all responses arrived");
  end

endmodule

// File: files.f
+incdir+.
obi_pkg.sv
obi_owner_fifo.sv
obi_adapter.sv
obi_arbiter.sv
obi_subsystem.sv
tb_obi_subsystem.sv

// File: Makefile
# Verilator simulation of the OBI front end

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert -Wno-fatal -f files.f --top-module tb_obi_subsystem -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir
